// File: vlog.f
+incdir+.
synth_pkg.sv
song_pos_if.sv
sample_clock.sv
chord_track.sv
bass_track.sv
note_freq.sv
note_player.sv
note_player_props.sv
tb_note_player.sv

// File: run.sh
#!/usr/bin/env bash
# Build the note player testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_note_player

output="$(./obj_dir/Vtb_note_player)"
echo "$output"

if grep -qx "RESULT: PASS" <<< "$output"; then
	exit 0
fi
exit 1

// File: note_player_tests.txt
# steps chords_on silence simple_bass chord_oct chord_mantissa bass_oct bass_mantissa raise_drum
# Decimal fields; steps add to the counter value left by the line before
1   0 0 0  7 118  4   2  0
3   0 0 0  7 118  3  46  0
4   0 0 0  2   2  4   2  0
4   0 0 0  2   2  7 118  0
8   0 0 0  2   2  4   2  0
32  0 0 1  2   2  3  46  0
4   0 0 1  2   2  4   2  0
16  0 0 0  2  46  3 104  0
20  0 0 0  2  46  7 118  0
4   0 0 0  2  46  3 104  0
8   0 1 0  7 118  3  46  0
32  0 1 0  7 118  4   2  0
4   0 0 0  2  67  7 118  0
60  0 0 0  2  36  3  36  0
4   1 0 0  2 118  7 118  0
24  1 0 0  2 118  3  67  0
16  1 0 1  2 118  3  36  0
20  0 0 0  2   2  4   2  0
192 0 0 0  2  36  3  36  1
55  0 0 0  2  36  7 118  1
1   0 0 0  7 118  4   2  0
448 1 1 0  7 118  3  67  1

// File: tb_note_player.sv
// Note player testbench
// Runs req/ack handshakes from the test file and checks the note outputs

`timescale 1ns/1ns

module tb_note_player;

	localparam int max_tests = 64;

	logic clk = 1'b0;
	logic reset;
	logic req;
	logic chords_on;
	logic silence;
	logic simple_bass;
	logic ack;
	synth_pkg::oct_t chord_oct;
	synth_pkg::mantissa_t chord_mantissa;
	synth_pkg::oct_t bass_oct;
	synth_pkg::mantissa_t bass_mantissa;
	logic raise_drum;

	int vals [max_tests][9];  // Steps, three controls, five expected outputs
	int test_count = 0;
	int total_steps = 0;
	int cycle_limit = 0;      // Zero until the file is read
	int cycles = 0;
	int errors = 0;
	int test_errors;
	int failed_tests = 0;
	int position = 0;         // Expected counter value
	int t;

	note_player u_note_player (
		.clk(clk),
		.reset(reset),
		.req(req),
		.chords_on(chords_on),
		.silence(silence),
		.simple_bass(simple_bass),
		.ack(ack),
		.chord_oct(chord_oct),
		.chord_mantissa(chord_mantissa),
		.bass_oct(bass_oct),
		.bass_mantissa(bass_mantissa),
		.raise_drum(raise_drum)
	);

	bind note_player note_player_props u_note_player_props (
		.clk(clk),
		.reset(reset),
		.req(req),
		.ack(ack),
		.silence(silence),
		.chord_oct(chord_oct),
		.sample_count(u_sample_clock.sample_count)
	);

	always #5 clk = ~clk;  // 10 ns period

	// ------------------------------------------------------------------------
	// Watchdog
	// ------------------------------------------------------------------------
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: a handshake stalled, run stopped after %0d cycles", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic read_tests();
		int fd;
		int n;
		string line;
		fd = $fopen("note_player_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test file note_player_tests.txt");
		end else begin
			while (!$feof(fd) && test_count < max_tests) begin
				n = $fgets(line, fd);
				// Comment and blank lines do not scan as nine numbers
				if (n > 0 && $sscanf(line, "%d %d %d %d %d %d %d %d %d",
						vals[test_count][0], vals[test_count][1], vals[test_count][2],
						vals[test_count][3], vals[test_count][4], vals[test_count][5],
						vals[test_count][6], vals[test_count][7],
						vals[test_count][8]) == 9) begin
					total_steps += vals[test_count][0];
					test_count++;
				end
			end
			$fclose(fd);
		end
	endtask

	// One four-phase cycle sampled on falling edges
	task automatic do_handshake();
		req = 1'b1;
		@(negedge clk);
		while (ack !== 1'b1) @(negedge clk);
		req = 1'b0;
		@(negedge clk);
		while (ack !== 1'b0) @(negedge clk);
	endtask

	task automatic check_field(input string name, input int got, input int expected);
		if (got != expected) begin
			$display("ERR t=%0t test %0d: %s got %0d expected %0d",
				$time, t + 1, name, got, expected);
			errors++;
			test_errors++;
		end
	endtask

	task automatic run_test();
		test_errors = 0;
		chords_on = (vals[t][1] != 0);  // Controls set before the steps
		silence = (vals[t][2] != 0);
		simple_bass = (vals[t][3] != 0);
		repeat (vals[t][0]) do_handshake();
		position = (position + vals[t][0]) % 512;  // Counter wraps
		check_field("chord_oct", int'(chord_oct), vals[t][4]);
		check_field("chord_mantissa", int'(chord_mantissa), vals[t][5]);
		check_field("bass_oct", int'(bass_oct), vals[t][6]);
		check_field("bass_mantissa", int'(bass_mantissa), vals[t][7]);
		check_field("raise_drum", int'(raise_drum), vals[t][8]);
		if (test_errors == 0) begin
			$display("test %0d: %0d steps to counter %0d, ok", t + 1, vals[t][0], position);
		end else begin
			$display("test %0d: %0d steps to counter %0d, %0d mismatches",
				t + 1, vals[t][0], position, test_errors);
			failed_tests++;
		end
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial begin
		reset = 1'b1;
		req = 1'b0;
		chords_on = 1'b0;
		silence = 1'b0;
		simple_bass = 1'b0;
		read_tests();
		cycle_limit = 8 * total_steps + 100;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		if (ack !== 1'b0) begin
			$display("ERR t=%0t ack is high right after reset", $time);
			errors++;
		end
		for (t = 0; t < test_count; t++) run_test();
		$display("Summary: %0d tests run, %0d failed, %0d errors",
			test_count, failed_tests, errors);
		if (errors == 0 && test_count > 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: note_player_props.sv
// Note player assertions
// Handshake order, counter stepping and chord muting, bound into the top level

`timescale 1ns/1ns

module note_player_props (
	input logic clk,
	input logic reset,
	input logic req,
	input logic ack,
	input logic silence,
	input synth_pkg::oct_t chord_oct,
	input synth_pkg::sample_count_t sample_count
);

	// ack only answers a req seen on the edge before
	ack_after_req: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> $past(req))
		else $error("ack rose without a preceding req");

	// Counter steps together with ack, never on its own
	count_on_ack: assert property (@(posedge clk) disable iff (reset)
		(sample_count != $past(sample_count)) |-> $rose(ack))
		else $error("sample counter changed without ack rising");

	mute_chord: assert property (@(posedge clk) disable iff (reset)
		silence |-> (chord_oct == synth_pkg::oct_t'(7)))  // Silent octave
		else $error("chord octave not silent while silence is high");

endmodule

// File: note_player.sv
// Note player top level
// Sample clock handshake feeding the chord and bass tracks,
// each track note turned into octave and mantissa

`timescale 1ns/1ns

module note_player (
	input logic clk,
	input logic reset,
	input logic req,
	input logic chords_on,
	input logic silence,
	input logic simple_bass,
	output logic ack,
	output synth_pkg::oct_t chord_oct,
	output synth_pkg::mantissa_t chord_mantissa,
	output synth_pkg::oct_t bass_oct,
	output synth_pkg::mantissa_t bass_mantissa,
	output logic raise_drum
);

	synth_pkg::note_t chord_note;
	synth_pkg::note_t bass_note;

	song_pos_if pos ();  // Decoded song position

	// ------------------------------------------------------------------------
	// Song position
	// ------------------------------------------------------------------------
	sample_clock u_sample_clock (
		.clk(clk),
		.reset(reset),
		.req(req),
		.ack(ack),
		.pos(pos)
	);

	// ------------------------------------------------------------------------
	// Tracks
	// ------------------------------------------------------------------------
	chord_track u_chord_track (
		.pos(pos),
		.chords_on(chords_on),
		.silence(silence),
		.chord_note(chord_note),
		.raise_drum(raise_drum)
	);

	bass_track u_bass_track (
		.pos(pos),
		.simple_bass(simple_bass),
		.bass_note(bass_note)
	);

	// One table per voice
	note_freq u_chord_freq (
		.note(chord_note),
		.oct(chord_oct),
		.mantissa(chord_mantissa)
	);

	note_freq u_bass_freq (
		.note(bass_note),
		.oct(bass_oct),
		.mantissa(bass_mantissa)
	);

endmodule

// File: note_freq.sv
// Note frequency lookup
// Splits a note code into octave and mantissa via the pitch table

`timescale 1ns/1ns
`include "synth_consts.svh"

module note_freq (
	input synth_pkg::note_t note,
	output synth_pkg::oct_t oct,
	output synth_pkg::mantissa_t mantissa
);

	// Equal-tempered steps, one octave downward from 246
	// MSB is always set and not carried on the output
	localparam logic [7:0] mantissa_rom [`NOTE_COUNT] = '{
		8'd246, 8'd232, 8'd219, 8'd207,
		8'd195, 8'd184, 8'd174, 8'd164,
		8'd155, 8'd146, 8'd138, 8'd130
	};

	synth_pkg::pitch_t pitch;
	logic [7:0] table_value;

	assign pitch = note[3:0];

	// ------------------------------------------------------------------------
	// Lookup
	// ------------------------------------------------------------------------
	always_comb begin
		if (pitch < `NOTE_COUNT)
			table_value = mantissa_rom[pitch];
		else
			table_value = '0;  // Undefined pitches
	end

	assign mantissa = table_value[6:0];
	assign oct = note[6:4];  // Low three bits of the high nibble

endmodule

// File: bass_track.sv
// Bass track
// Two bass notes per chord, played to one of three sixteen-step
// rhythm patterns; unused steps are rests

`timescale 1ns/1ns
`include "synth_consts.svh"

module bass_track (
	song_pos_if.sink pos,
	input logic simple_bass,
	output synth_pkg::note_t bass_note
);

	localparam synth_pkg::note_t rest_note = {1'b0, 3'(`SILENT_OCT), 4'h0};

	synth_pkg::note_t first_note;   // Root side of the pair
	synth_pkg::note_t second_note;  // Upper note
	logic last_chord;

	assign last_chord = (pos.track_pos == synth_pkg::track_pos_t'(3));

	// ------------------------------------------------------------------------
	// Note pair per chord
	// ------------------------------------------------------------------------
	always_comb begin
		case (pos.track_pos)
			2'd0: begin
				first_note = 8'h4B;   // C
				second_note = 8'h36;  // G
			end
			2'd1: begin
				first_note = 8'h31;   // D
				second_note = 8'h36;  // G
			end
			2'd2: begin
				first_note = 8'h4B;   // C
				second_note = 8'h34;  // F
			end
			default: begin
				first_note = 8'h34;   // F
				second_note = 8'h37;  // Ab
			end
		endcase
	end

	// ------------------------------------------------------------------------
	// Rhythm
	// ------------------------------------------------------------------------
	always_comb begin
		if (simple_bass) begin
			case (pos.bass_pos)
				4'd0, 4'd2, 4'd4, 4'd8, 4'd12, 4'd14: bass_note = first_note;
				4'd1, 4'd6, 4'd10, 4'd13: bass_note = second_note;
				default: bass_note = rest_note;
			endcase
		end else if (!last_chord) begin
			// Normal bar
			case (pos.bass_pos)
				4'd0, 4'd2, 4'd4, 4'd5, 4'd8, 4'd12, 4'd13: bass_note = first_note;
				4'd1, 4'd6, 4'd10, 4'd14: bass_note = second_note;
				default: bass_note = rest_note;
			endcase
		end else begin
			// Last bar, sparser
			case (pos.bass_pos)
				4'd0, 4'd4, 4'd8, 4'd9, 4'd12: bass_note = first_note;
				4'd2, 4'd6, 4'd10, 4'd14: bass_note = second_note;
				default: bass_note = rest_note;
			endcase
		end
	end

endmodule

// File: chord_track.sv
// Chord track
// Picks the chord root for each song position, silences it in the
// gap or on request, and flags the bar where the drum goes up

`timescale 1ns/1ns
`include "synth_consts.svh"

module chord_track (
	song_pos_if.sink pos,
	input logic chords_on,
	input logic silence,
	output synth_pkg::note_t chord_note,
	output logic raise_drum
);

	// Silent code, pitch nibble don't care
	localparam synth_pkg::note_t silent_note = {1'b0, 3'(`SILENT_OCT), 4'h0};

	synth_pkg::note_t chord_root;

	// ------------------------------------------------------------------------
	// Chord sequence
	// ------------------------------------------------------------------------
	// All codes lowered by one pitch step, C wraps down an octave
	always_comb begin
		case (pos.track_pos)
			2'd0: chord_root = 8'h2B;  // C
			2'd1: chord_root = 8'h26;  // G
			2'd2: chord_root = 8'h24;  // F
			default: begin
				// Last chord depends on the chord mode
				if (chords_on)
					chord_root = 8'h20;  // Db
				else
					chord_root = 8'h27;  // Ab
			end
		endcase
	end

	// Gap at the start of each chord, or muted outright
	assign chord_note = (pos.chord_gap || silence) ? silent_note : chord_root;

	// ------------------------------------------------------------------------
	// Drum raise
	// ------------------------------------------------------------------------
	// Only on the last chord of the second pass
	assign raise_drum = (pos.track_pos == synth_pkg::track_pos_t'(3)) && pos.second_loop;

endmodule

// File: sample_clock.sv
// Sample clock
// Four-phase req/ack handshake, one counter step per handshake,
// and decoding of the counter into the song position

`timescale 1ns/1ns
`include "synth_consts.svh"

module sample_clock (
	input logic clk,
	input logic reset,
	input logic req,
	output logic ack,
	song_pos_if.source pos
);

	synth_pkg::hs_state_t state;
	synth_pkg::sample_count_t sample_count;

	// ------------------------------------------------------------------------
	// Handshake FSM and counter
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= synth_pkg::IDLE;
			sample_count <= '0;
		end else begin
			case (state)
				synth_pkg::IDLE: if (req) begin
					sample_count <= sample_count + synth_pkg::sample_count_t'(1); // Wraps at 512
					state <= synth_pkg::ACKED;
				end
				default: if (!req) state <= synth_pkg::IDLE; // Drop ack next edge
			endcase
		end
	end

	assign ack = (state == synth_pkg::ACKED); // Rises with the counter step

	// ------------------------------------------------------------------------
	// Position decoding
	// ------------------------------------------------------------------------
	assign pos.track_pos = sample_count[`TRACK_LOG2_WAIT +: `TRACK_POS_BITS];
	assign pos.second_loop = sample_count[`TRACK_LOG2_WAIT + `TRACK_POS_BITS]; // Top bit
	assign pos.bass_pos = sample_count[`BASS_LOG2_WAIT +: `BASS_POS_BITS];

	// First eighth of every chord is silent
	assign pos.chord_gap =
		(sample_count[`TRACK_LOG2_WAIT-1 -: `LOG2_SILENCE_CHORD] == '0);

endmodule

// File: song_pos_if.sv
// Song position bus
// Decoded fields of the sample counter, fanned out to the tracks

`timescale 1ns/1ns

interface song_pos_if;

	synth_pkg::track_pos_t track_pos;  // Which chord
	logic second_loop;                 // Second pass through the chords
	synth_pkg::bass_pos_t bass_pos;    // Step within the chord
	logic chord_gap;                   // Short silent gap at chord start

	// Driven by the sample counter
	modport source (
		output track_pos,
		output second_loop,
		output bass_pos,
		output chord_gap
	);

	// Read by the note tracks
	modport sink (
		input track_pos,
		input second_loop,
		input bass_pos,
		input chord_gap
	);

endinterface

// File: synth_pkg.sv
// Chiptune note sequencer types
// Note codes, table values, song positions and handshake states

`include "synth_consts.svh"

package synth_pkg;

	// Note code: octave nibble high, pitch nibble low
	typedef logic [7:0] note_t;
	typedef logic [3:0] pitch_t;
	typedef logic [2:0] oct_t;

	// Mantissa with its always-set MSB dropped
	typedef logic [6:0] mantissa_t;

	// Song position fields
	typedef logic [`TRACK_POS_BITS-1:0] track_pos_t;
	typedef logic [`BASS_POS_BITS-1:0] bass_pos_t;
	typedef logic [`SAMPLE_BITS-1:0] sample_count_t;

	// Four-phase req/ack
	typedef enum logic {
		IDLE,   // Waiting for req
		ACKED   // ack high, waiting for req to drop
	} hs_state_t;

endpackage

// File: synth_consts.svh
// Chiptune note sequencer constants
// Song layout of the sample counter and the note code encoding

`ifndef SYNTH_CONSTS_SVH
`define SYNTH_CONSTS_SVH

// ------------------------------------------------------------------------
// Sample counter layout
// ------------------------------------------------------------------------
`define SAMPLE_BITS 9              // Counter width, one song pass per wrap

`define TRACK_LOG2_WAIT 6          // Chord position starts here
`define TRACK_POS_BITS 2           // Four chords per loop

`define BASS_LOG2_WAIT 2           // Bass step starts here
`define BASS_POS_BITS 4            // Sixteen bass steps per chord

// Gap field sits just below the chord position
`define LOG2_SILENCE_CHORD 3

// ------------------------------------------------------------------------
// Note codes
// ------------------------------------------------------------------------
`define SILENT_OCT 7               // Octave 7 plays nothing
`define NOTE_COUNT 12              // Pitches 0..11, rest undefined

`endif
